// File: src/cache_pkg.sv
package cache_pkg;

    // address split: tag | index | byte offset
    localparam int OFFSET_W = 5;
    localparam int INDEX_W = 4;
    localparam int TAG_W = 32 - INDEX_W - OFFSET_W;

    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] mask_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // dirty flag sits above the tag bits
    typedef struct packed {
        logic dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // tree bits: [0] half select, [1] ways 0/1, [2] ways 2/3
    typedef logic [2:0] plru_t;

endpackage

// File: src/cache_ifs.sv
interface array_if import cache_pkg::*; ();

    index_t index;
    logic wr_en;
    way_t wr_way;
    line_t wr_line;
    tag_entry_t wr_tag;
    logic set_valid;

    // per-way read data, one cycle behind index
    line_t lines [NUM_WAYS];
    tag_entry_t tags [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid;

    modport ctrl (
        output index,
        output wr_en,
        output wr_way,
        output wr_line,
        output wr_tag,
        output set_valid,
        input  lines,
        input  tags,
        input  valid
    );

    modport storage (
        input  index,
        input  wr_en,
        input  wr_way,
        input  wr_line,
        input  wr_tag,
        input  set_valid,
        output lines,
        output tags,
        output valid
    );

endinterface

interface plru_if import cache_pkg::*; ();

    index_t index;
    logic touch;
    way_t touch_way;
    way_t victim;

    modport ctrl (
        output index,
        output touch,
        output touch_way,
        input  victim
    );

    modport tree (
        input  index,
        input  touch,
        input  touch_way,
        output victim
    );

endinterface

// File: src/sync_ram.sv
module sync_ram import cache_pkg::*; #(
    parameter type data_t = logic [31:0]
) (
    input  logic   clk,
    input  index_t addr,
    input  logic   we,
    input  data_t  din,
    output data_t  dout
);

    data_t mem [NUM_SETS];

    // write-first: a write shows up on dout the next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            dout <= din;
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

// File: src/set_storage.sv
module set_storage import cache_pkg::*; (
    input logic      clk,
    input logic      rst,
    array_if.storage arr
);

    logic [NUM_WAYS-1:0] valid_bits [NUM_SETS];
    logic [NUM_WAYS-1:0] valid_row;
    logic [NUM_WAYS-1:0] valid_q;

    // addressed row with the pending write folded in
    always_comb begin
        valid_row = valid_bits[arr.index];
        if (arr.wr_en) begin
            valid_row[arr.wr_way] = arr.set_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_bits[s] <= '0;
            end
            valid_q <= '0;
        end else begin
            valid_bits[arr.index] <= valid_row;
            valid_q <= valid_row;
        end
    end

    assign arr.valid = valid_q;

    generate
        for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
            logic way_we;

            assign way_we = arr.wr_en && (arr.wr_way == way_t'(w));

            sync_ram #(
                .data_t (line_t)
            ) u_line_ram (
                .clk  (clk),
                .addr (arr.index),
                .we   (way_we),
                .din  (arr.wr_line),
                .dout (arr.lines[w])
            );

            sync_ram #(
                .data_t (tag_entry_t)
            ) u_tag_ram (
                .clk  (clk),
                .addr (arr.index),
                .we   (way_we),
                .din  (arr.wr_tag),
                .dout (arr.tags[w])
            );
        end
    endgenerate

endmodule

// File: src/plru_tree.sv
module plru_tree import cache_pkg::*; (
    input logic   clk,
    input logic   rst,
    plru_if.tree  lru
);

    plru_t plru_state [NUM_SETS];
    plru_t cur;
    plru_t upd;

    assign cur = plru_state[lru.index];

    // walk the tree away from recent accesses
    always_comb begin
        if (cur[0]) begin
            lru.victim = cur[1] ? way_t'(0) : way_t'(1);
        end else begin
            lru.victim = cur[2] ? way_t'(2) : way_t'(3);
        end
    end

    // point the tree at the other half after a touch
    always_comb begin
        upd = cur;
        unique case (lru.touch_way)
            2'd0: begin
                upd[0] = 1'b0;
                upd[1] = 1'b0;
            end
            2'd1: begin
                upd[0] = 1'b0;
                upd[1] = 1'b1;
            end
            2'd2: begin
                upd[0] = 1'b1;
                upd[2] = 1'b0;
            end
            default: begin
                upd[0] = 1'b1;
                upd[2] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_state[s] <= '0;
            end
        end else if (lru.touch) begin
            plru_state[lru.index] <= upd;
        end
    end

endmodule

// File: src/word_merge.sv
module word_merge import cache_pkg::*; (
    input  line_t               line,
    input  logic [OFFSET_W-1:0] offset,
    input  mask_t               rmask,
    input  mask_t               wmask,
    input  word_t               wdata,
    output word_t               rdata,
    output line_t               merged
);

    logic [OFFSET_W-3:0] word_sel;
    word_t cur_word;
    word_t new_word;

    assign word_sel = offset[OFFSET_W-1:2];
    assign cur_word = line[word_sel*32 +: 32];

    // per byte: zero on read, old byte kept on write
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rdata[b*8 +: 8] = rmask[b] ? cur_word[b*8 +: 8] : 8'h00;
            new_word[b*8 +: 8] = wmask[b] ? wdata[b*8 +: 8] : cur_word[b*8 +: 8];
        end
    end

    always_comb begin
        merged = line;
        merged[word_sel*32 +: 32] = new_word;
    end

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  addr_t ufp_addr,
    input  mask_t ufp_rmask,
    input  mask_t ufp_wmask,
    output word_t ufp_rdata,
    output logic  ufp_resp,

    output addr_t dfp_addr,
    output logic  dfp_read,
    output logic  dfp_write,
    output line_t dfp_wdata,
    input  line_t dfp_rdata,
    input  logic  dfp_resp,

    array_if.ctrl arr,
    plru_if.ctrl  lru,

    output line_t sel_line,
    input  word_t rdata,
    input  line_t merged
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL,
        ST_REREAD
    } state_t;

    state_t state;
    state_t state_next;

    addr_t req_addr;
    logic req_write;
    way_t victim_q;

    logic [TAG_W-1:0] req_tag;
    index_t req_index;
    logic req_valid;

    logic [NUM_WAYS-1:0] hit_vec;
    logic hit;
    way_t hit_way;
    logic victim_dirty;

    assign req_valid = (ufp_rmask != '0) || (ufp_wmask != '0);
    assign req_tag = req_addr[31 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request stage, held until the answer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            req_addr <= ufp_addr;
            req_write <= (ufp_wmask != '0);
        end
        if (state == ST_COMPARE && !hit) begin
            victim_q <= lru.victim;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = arr.valid[w] && (arr.tags[w].tag == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign victim_dirty = arr.valid[lru.victim] && arr.tags[lru.victim].dirty;

    always_comb begin
        state_next = state;
        unique case (state)
            ST_IDLE: begin
                if (req_valid) begin
                    state_next = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (hit) begin
                    state_next = ST_IDLE;
                end else if (victim_dirty) begin
                    state_next = ST_WRITEBACK;
                end else begin
                    state_next = ST_FILL;
                end
            end
            ST_WRITEBACK: begin
                if (dfp_resp) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (dfp_resp) begin
                    state_next = ST_REREAD;
                end
            end
            ST_REREAD: state_next = ST_COMPARE;
            default: state_next = ST_IDLE;
        endcase
    end

    // array port: write hit merges, fill installs the new line
    always_comb begin
        arr.index = (state == ST_IDLE) ? ufp_addr[OFFSET_W +: INDEX_W] : req_index;
        arr.wr_en = 1'b0;
        arr.wr_way = hit_way;
        arr.wr_line = merged;
        arr.wr_tag = '{dirty: 1'b1, tag: req_tag};
        arr.set_valid = 1'b1;
        if (state == ST_COMPARE && hit && req_write) begin
            arr.wr_en = 1'b1;
        end else if (state == ST_FILL && dfp_resp) begin
            arr.wr_en = 1'b1;
            arr.wr_way = victim_q;
            arr.wr_line = dfp_rdata;
            arr.wr_tag = '{dirty: 1'b0, tag: req_tag};
        end
    end

    assign lru.index = req_index;
    assign lru.touch = (state == ST_COMPARE) && hit;
    assign lru.touch_way = hit_way;

    assign sel_line = arr.lines[hit_way];

    assign ufp_resp = (state == ST_COMPARE) && hit;
    assign ufp_rdata = (ufp_resp && !req_write) ? rdata : '0;

    // victim goes back to the address its stored tag names
    assign dfp_read = (state == ST_FILL);
    assign dfp_write = (state == ST_WRITEBACK);
    assign dfp_addr = (state == ST_WRITEBACK)
        ? {arr.tags[victim_q].tag, req_index, {OFFSET_W{1'b0}}}
        : {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign dfp_wdata = arr.lines[victim_q];

endmodule

// File: src/cache_top.sv
module cache_top import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  addr_t ufp_addr,
    input  mask_t ufp_rmask,
    input  mask_t ufp_wmask,
    input  word_t ufp_wdata,
    output word_t ufp_rdata,
    output logic  ufp_resp,

    output addr_t dfp_addr,
    output logic  dfp_read,
    output logic  dfp_write,
    output line_t dfp_wdata,
    input  line_t dfp_rdata,
    input  logic  dfp_resp
);

    array_if arr ();
    plru_if lru ();

    line_t sel_line;
    word_t sel_rdata;
    line_t merged_line;

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .arr       (arr),
        .lru       (lru),
        .sel_line  (sel_line),
        .rdata     (sel_rdata),
        .merged    (merged_line)
    );

    set_storage u_storage (
        .clk (clk),
        .rst (rst),
        .arr (arr)
    );

    plru_tree u_plru (
        .clk (clk),
        .rst (rst),
        .lru (lru)
    );

    // request inputs stay stable until ufp_resp
    word_merge u_merge (
        .line   (sel_line),
        .offset (ufp_addr[OFFSET_W-1:0]),
        .rmask  (ufp_rmask),
        .wmask  (ufp_wmask),
        .wdata  (ufp_wdata),
        .rdata  (sel_rdata),
        .merged (merged_line)
    );

endmodule

// File: testbench/mem_model.sv
module mem_model import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t dfp_addr,
    input  logic  dfp_read,
    input  logic  dfp_write,
    input  line_t dfp_wdata,
    output line_t dfp_rdata,
    output logic  dfp_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESP_DELAY = 3;

    line_t mem [addr_t];
    // first contents of every line, never overwritten
    line_t init_lines [addr_t];
    int seed = 32'h356f;

    int reads = 0;
    int writes = 0;
    int ops = 0;
    int last_rd_op = 0;
    int last_wr_op = 0;
    addr_t last_rd_addr = '0;
    addr_t last_wr_addr = '0;
    line_t last_wr_line = '0;
    int wait_cnt = 0;

    function automatic line_t fresh_line();
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // strobe and address are sampled at the falling edge
    task automatic serve();
        addr_t a;
        logic is_write;
        a = dfp_addr;
        is_write = dfp_write;
        ops++;
        if (is_write) begin
            mem[a] = dfp_wdata;
            writes++;
            last_wr_addr = a;
            last_wr_line = dfp_wdata;
            last_wr_op = ops;
        end else begin
            if (!mem.exists(a)) begin
                mem[a] = fresh_line();
                init_lines[a] = mem[a];
            end
            reads++;
            last_rd_addr = a;
            last_rd_op = ops;
        end
        @(posedge clk);
        #1;
        dfp_rdata = is_write ? '0 : mem[a];
        dfp_resp = 1'b1;
        @(posedge clk);
        #1;
        dfp_resp = 1'b0;
        wait_cnt = 0;
    endtask

    initial begin
        dfp_resp = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst || !(dfp_read || dfp_write)) begin
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt == RESP_DELAY) begin
                    serve();
                end
            end
        end
    end

endmodule

// File: testbench/cache_tb.sv
module cache_tb import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic rst;
    addr_t ufp_addr;
    mask_t ufp_rmask;
    mask_t ufp_wmask;
    word_t ufp_wdata;
    word_t ufp_rdata;
    logic ufp_resp;
    addr_t dfp_addr;
    logic dfp_read;
    logic dfp_write;
    line_t dfp_wdata;
    line_t dfp_rdata;
    logic dfp_resp;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycle_count = 0;

    // reference view of the cache and of memory contents
    logic [TAG_W-1:0] m_tag [NUM_SETS][NUM_WAYS];
    logic m_valid [NUM_SETS][NUM_WAYS];
    logic m_dirty [NUM_SETS][NUM_WAYS];
    plru_t m_plru [NUM_SETS];
    line_t model_mem [addr_t];

    cache_top dut (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [255:0] got,
                         input logic [255:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error: %s is %0h, expected %0h", name, got, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // bit 0 picks the half, bit 1 or bit 2 the way inside it
    function automatic way_t plru_victim(plru_t p);
        case ({p[0], p[0] ? p[1] : p[2]})
            2'b11: return 2'd0;
            2'b10: return 2'd1;
            2'b01: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic plru_t plru_touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        n[0] = w[1];
        if (w[1]) begin
            n[2] = w[0];
        end else begin
            n[1] = w[0];
        end
        return n;
    endfunction

    function automatic word_t word_of(line_t l, addr_t a);
        return l[a[4:2]*32 +: 32];
    endfunction

    function automatic word_t mask_bytes(word_t w, mask_t m);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[b*8 +: 8] = m[b] ? w[b*8 +: 8] : 8'h00;
        end
        return r;
    endfunction

    function automatic line_t merge_bytes(line_t l, addr_t a, mask_t m, word_t d);
        line_t r;
        r = l;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                r[a[4:2]*32 + b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic addr_t set_addr(logic [TAG_W-1:0] tag, int set_idx);
        return {tag, index_t'(set_idx), {OFFSET_W{1'b0}}};
    endfunction

    // one request with its memory traffic predicted and checked
    task automatic access(input addr_t addr, input mask_t rmask, input mask_t wmask,
                          input word_t wdata, output word_t rdata);
        addr_t line_a;
        addr_t wb_addr;
        logic [TAG_W-1:0] tag;
        int set_idx;
        int way;
        int reads0;
        int writes0;
        int cycles;
        logic hit;
        logic expect_wb;
        line_a = {addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
        tag = addr[31 -: TAG_W];
        set_idx = int'(addr[OFFSET_W +: INDEX_W]);
        way = -1;
        expect_wb = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            way = int'(plru_victim(m_plru[set_idx]));
            expect_wb = m_valid[set_idx][way] && m_dirty[set_idx][way];
            wb_addr = set_addr(m_tag[set_idx][way], set_idx);
        end
        reads0 = u_mem.reads;
        writes0 = u_mem.writes;
        @(posedge clk);
        #1;
        ufp_addr = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp);
        rdata = ufp_rdata;
        @(posedge clk);
        #1;
        ufp_rmask = '0;
        ufp_wmask = '0;
        if (hit) begin
            check("hit latency in cycles", cycles, 2);
            check("memory reads on hit", u_mem.reads - reads0, 0);
            check("memory writes on hit", u_mem.writes - writes0, 0);
        end else begin
            check("memory reads on miss", u_mem.reads - reads0, 1);
            check("memory writes on miss", u_mem.writes - writes0, expect_wb ? 1 : 0);
            check("dfp_addr of fill", u_mem.last_rd_addr, line_a);
            if (expect_wb) begin
                check("dfp_addr of write-back", u_mem.last_wr_addr, wb_addr);
                check("dfp_wdata of write-back", u_mem.last_wr_line, model_mem[wb_addr]);
                if (u_mem.last_wr_op > u_mem.last_rd_op) begin
                    errors++;
                    $display("write-back did not come before the fill read of %h", line_a);
                end
            end
            if (!model_mem.exists(line_a)) begin
                model_mem[line_a] = u_mem.init_lines[line_a];
            end
            m_tag[set_idx][way] = tag;
            m_valid[set_idx][way] = 1'b1;
            m_dirty[set_idx][way] = 1'b0;
        end
        if (wmask != '0) begin
            model_mem[line_a] = merge_bytes(model_mem[line_a], addr, wmask, wdata);
            m_dirty[set_idx][way] = 1'b1;
        end else begin
            check("ufp_rdata", rdata, mask_bytes(word_of(model_mem[line_a], addr), rmask));
        end
        m_plru[set_idx] = plru_touch(m_plru[set_idx], way_t'(way));
    endtask

    task automatic test_reset_and_first_read();
        int e0;
        word_t rd;
        e0 = errors;
        @(negedge clk);
        check("ufp_resp", ufp_resp, 0);
        check("dfp_read", dfp_read, 0);
        check("dfp_write", dfp_write, 0);
        access(32'h0000_1234, 4'b0110, 4'b0000, '0, rd);
        check("ufp_rdata", rd,
              mask_bytes(word_of(u_mem.init_lines[32'h0000_1220], 32'h0000_1234), 4'b0110));
        end_test("reset_and_first_read", e0);
    endtask

    task automatic test_read_hit();
        int e0;
        word_t rd;
        e0 = errors;
        access(32'h0000_1230, 4'b1111, 4'b0000, '0, rd);
        end_test("read_hit", e0);
    endtask

    task automatic test_partial_write();
        int e0;
        word_t old_w;
        word_t rd;
        e0 = errors;
        old_w = word_of(u_mem.init_lines[32'h0000_1220], 32'h0000_1228);
        access(32'h0000_1228, 4'b1111, 4'b0000, '0, rd);
        access(32'h0000_1228, 4'b0000, 4'b0101, 32'ha1b2_c3d4, rd);
        access(32'h0000_1228, 4'b1111, 4'b0000, '0, rd);
        check("ufp_rdata after partial write", rd,
              {old_w[31:24], 8'hb2, old_w[15:8], 8'hd4});
        end_test("partial_write", e0);
    endtask

    // five lines in set 5; the written one is the PLRU victim at the end
    task automatic test_plru_eviction();
        int e0;
        word_t rd;
        e0 = errors;
        access(set_addr(23'h10, 5) + 8, 4'b0000, 4'b0011, 32'h5a5a_1234, rd);
        access(set_addr(23'h11, 5), 4'b1111, 4'b0000, '0, rd);
        access(set_addr(23'h12, 5), 4'b1111, 4'b0000, '0, rd);
        access(set_addr(23'h13, 5), 4'b1111, 4'b0000, '0, rd);
        access(set_addr(23'h14, 5), 4'b1111, 4'b0000, '0, rd);
        check("dfp_addr of write-back", u_mem.last_wr_addr, set_addr(23'h10, 5));
        end_test("plru_eviction", e0);
    endtask

    task automatic test_clean_eviction();
        int e0;
        int writes0;
        word_t rd;
        e0 = errors;
        writes0 = u_mem.writes;
        access(set_addr(23'h15, 5), 4'b1111, 4'b0000, '0, rd);
        check("memory writes on clean eviction", u_mem.writes - writes0, 0);
        access(set_addr(23'h10, 5) + 8, 4'b1111, 4'b0000, '0, rd);
        check("ufp_rdata of refilled line", rd,
              {u_mem.init_lines[set_addr(23'h10, 5)][2*32+16 +: 16], 16'h1234});
        end_test("clean_eviction", e0);
    endtask

    initial begin
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_tag[s][w] = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_and_first_read();
        test_read_hit();
        test_partial_write();
        test_plru_eviction();
        test_clean_eviction();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
src/cache_pkg.sv
src/cache_ifs.sv
src/sync_ram.sv
src/set_storage.sv
src/plru_tree.sv
src/word_merge.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/mem_model.sv
testbench/cache_tb.sv

// File: Makefile
TOP = cache_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

obj_dir/V$(TOP): files.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f files.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f files.f --top-module cache_top

clean:
	rm -rf obj_dir sim.log
